// File: sim.f
rtl/claw_pkg.sv
rtl/angle_trig.sv
rtl/key_pulse.sv
rtl/score_counter.sv
rtl/item_ram.sv
rtl/claw_controller.sv
rtl/claw_top.sv
dv/claw_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = claw_tb
FILELIST  = sim.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
PASS_MSG  = All tests passed!

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the status of the pipe is the status of grep
run: compile
	./$(SIM) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: dv/claw_tb.sv
// claw testbench: table driven fire and drop rows checked against a reference tip model
`default_nettype none

module claw_tb;
    import claw_pkg::*;

    typedef struct {
        int         x;
        int         y;
        item_type_e kind;
        int         angle;    // fire at this swing angle
        bit         hit;
        bit         hold;     // fire_key stays high after the row
        int         score;    // total after the row
    } row_t;

    localparam int ROWS = 4;
    localparam int SIN_TAB [10] = '{0, 44, 88, 128, 165, 196, 222, 241, 252, 256};

    logic               clock;
    logic               resetn;
    logic               enable;
    logic               draw_busy;
    logic               fire_key;
    logic [ITEM_AW-1:0] draw_index;
    logic               load_en;
    logic [ITEM_AW-1:0] load_index;
    logic [31:0]        load_data;
    logic [9:0]         degree;
    logic [9:0]         end_x;
    logic [9:0]         end_y;
    logic [9:0]         rope_len;
    logic [31:0]        draw_data;
    logic [9:0]         score;
    logic               hooked;

    row_t        rows [ROWS];
    logic [31:0] items [ITEM_COUNT];    // reference copy of the item memory
    logic [31:0] rng_state;
    int          ref_score;

    claw_top uut (
        .clock      (clock),
        .resetn     (resetn),
        .enable     (enable),
        .draw_busy  (draw_busy),
        .fire_key   (fire_key),
        .draw_index (draw_index),
        .load_en    (load_en),
        .load_index (load_index),
        .load_data  (load_data),
        .degree     (degree),
        .end_x      (end_x),
        .end_y      (end_y),
        .rope_len   (rope_len),
        .draw_data  (draw_data),
        .score      (score),
        .hooked     (hooked)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic check_degree(input logic [9:0] exp);
        if (degree !== exp)
            stop_on_error($sformatf("MISMATCH t=%0t degree exp=%0d got=%0d", $time, exp, degree));
    endtask

    task automatic check_len(input string what, input logic [9:0] exp, input logic [9:0] got);
        if (got !== exp)
            stop_on_error($sformatf("MISMATCH t=%0t %s exp=%0d got=%0d", $time, what, exp, got));
    endtask

    task automatic check_tip(input logic [9:0] exp_x, input logic [9:0] exp_y);
        if (end_x !== exp_x)
            stop_on_error($sformatf("MISMATCH t=%0t end_x exp=%0d got=%0d", $time, exp_x, end_x));
        if (end_y !== exp_y)
            stop_on_error($sformatf("MISMATCH t=%0t end_y exp=%0d got=%0d", $time, exp_y, end_y));
    endtask

    task automatic check_score(input logic [9:0] exp);
        if (score !== exp)
            stop_on_error($sformatf("MISMATCH t=%0t score exp=%0d got=%0d", $time, exp, score));
    endtask

    task automatic check_hooked(input bit exp, input bit got);
        if (got !== exp)
            stop_on_error($sformatf("MISMATCH t=%0t hooked exp=%0b got=%0b", $time, exp, got));
    endtask

    function automatic logic [31:0] make_word(input int x, input int y, input item_type_e kind,
                                              input bit vis, input bit hook);
        logic [31:0] w;
        w = '0;
        w[ITEM_X_HI:ITEM_X_LO]       = 9'(x);
        w[ITEM_Y_HI:ITEM_Y_LO]       = 8'(y);
        w[ITEM_TYPE_HI:ITEM_TYPE_LO] = kind;
        w[ITEM_VIS_BIT]              = vis;
        w[ITEM_HOOK_BIT]             = hook;
        return w;
    endfunction

    // reads one entry through the renderer port
    task automatic check_item_word(input int idx, input int x, input int y,
                                   input item_type_e kind, input bit vis, input bit hook);
        logic [31:0] exp;
        exp = make_word(x, y, kind, vis, hook);
        @(posedge clock);
        draw_index <= ITEM_AW'(idx);
        @(posedge clock);
        @(negedge clock);
        if (draw_data !== exp)
            stop_on_error($sformatf("MISMATCH t=%0t draw_data[%0d] exp=%08h got=%08h",
                                    $time, idx, exp, draw_data));
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] v;
        v = s ^ (s << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    function automatic int item_value(input item_type_e kind);
        case (kind)
            ITEM_GOLD:    return 2;
            ITEM_DIAMOND: return 5;
            default:      return 1;
        endcase
    endfunction

    function automatic int tip_x(input int len, input int a);
        int cs;
        int dx;
        cs = (a <= 90) ? SIN_TAB[(90 - a) / 10] : SIN_TAB[(a - 90) / 10];
        dx = (len * cs) / 256;
        return (a > 90) ? int'(ORIGIN_X) - dx : int'(ORIGIN_X) + dx;    // left of pivot past 90
    endfunction

    function automatic int tip_y(input int len, input int a);
        int sn;
        sn = (a <= 90) ? SIN_TAB[a / 10] : SIN_TAB[(180 - a) / 10];
        return int'(ORIGIN_Y) + (len * sn) / 256;
    endfunction

    function automatic bit tip_out(input int len, input int a);
        int ex;
        int ey;
        ex = tip_x(len, a);
        ey = tip_y(len, a);
        return ex <= int'(X_LO) || ex >= int'(X_HI) || ey >= int'(Y_HI) || len >= int'(ROPE_MAX);
    endfunction

    function automatic bit item_hit(input logic [31:0] w, input int ex, input int ey);
        int x;
        int y;
        x = int'(w[ITEM_X_HI:ITEM_X_LO]);
        y = int'(w[ITEM_Y_HI:ITEM_Y_LO]);
        return w[ITEM_VIS_BIT] && !w[ITEM_HOOK_BIT]
               && x < ex && ex < x + int'(ITEM_BOX)
               && y < ey && ey < y + int'(ITEM_BOX);
    endfunction

    // longest rope of a drop at angle a, and the first entry it hooks
    function automatic int predict_drop(input int a, output int hit_idx);
        int len;
        bit done;
        len     = int'(ROPE_MIN);
        hit_idx = -1;
        done    = 1'b0;
        while (!done) begin
            if (tip_out(len, a)) begin
                done = 1'b1;
            end else begin
                len = (len + int'(DROP_STEP) > int'(ROPE_MAX)) ? int'(ROPE_MAX)
                                                                : len + int'(DROP_STEP);
                for (int i = 0; i < ITEM_COUNT; i++) begin
                    if (!done && item_hit(items[i], tip_x(len, a), tip_y(len, a))) begin
                        hit_idx = i;
                        done    = 1'b1;
                    end
                end
            end
        end
        return len;
    endfunction

    // next swing step, rope must stay at the top meanwhile
    task automatic wait_degree_step();
        logic [9:0] prev;
        bit         done;
        prev = degree;
        done = 1'b0;
        for (int n = 0; n < 4 * FRAME_CYCLES && !done; n++) begin
            @(negedge clock);
            check_len("rope_len while swinging", ROPE_MIN, rope_len);
            done = (degree != prev);
        end
        if (!done)
            stop_on_error("timeout waiting for the swing angle to step");
    endtask

    task automatic wait_angle(input logic [9:0] angle);
        logic [9:0] prev;
        bit         done;
        prev = degree;
        done = 1'b0;
        for (int n = 0; n < 1000 && !done; n++) begin
            @(negedge clock);
            done = (degree == angle) && (prev != angle);    // fresh arrival only
            prev = degree;
        end
        if (!done)
            stop_on_error("timeout waiting for the claw to swing to the fire angle");
    endtask

    // renderer busy once the rope is on its way down, long enough to span a scan
    task automatic hold_busy_in_drop();
        logic [9:0] held;
        bit         done;
        done = 1'b0;
        for (int n = 0; n < 100 * FRAME_CYCLES && !done; n++) begin
            @(negedge clock);
            done = (rope_len != ROPE_MIN);
        end
        if (!done)
            stop_on_error("timeout waiting for the rope to start down");
        @(posedge clock);
        draw_busy <= 1'b1;
        @(negedge clock);
        held = rope_len;
        repeat (16 * FRAME_CYCLES) begin
            @(negedge clock);
            check_len("rope_len while busy", held, rope_len);
        end
        @(posedge clock);
        draw_busy <= 1'b0;
    endtask

    task automatic run_drop(input logic [9:0] angle, output int max_len, output bit saw_hook);
        logic [9:0] prev;
        logic [9:0] step;
        bit         rising;
        bit         done;
        prev     = rope_len;
        rising   = 1'b1;
        done     = 1'b0;
        max_len  = int'(rope_len);
        saw_hook = 1'b0;
        for (int n = 0; n < 20000 && !done; n++) begin
            @(negedge clock);
            check_degree(angle);
            check_tip(10'(tip_x(int'(rope_len), int'(angle))),
                      10'(tip_y(int'(rope_len), int'(angle))));
            saw_hook = saw_hook | hooked;
            if (rope_len != prev) begin
                if (rope_len < prev)
                    rising = 1'b0;
                if (rising) begin
                    step = prev + DROP_STEP;
                    if (step > ROPE_MAX)
                        step = ROPE_MAX;
                end else begin
                    step = prev - REEL_STEP;
                end
                check_len("rope_len step", step, rope_len);
                if (rising)
                    max_len = int'(rope_len);
                prev = rope_len;
                done = !rising && (rope_len == ROPE_MIN);
            end
        end
        if (!done)
            stop_on_error("timeout waiting for the rope to come back up");
    endtask

    task automatic wait_unhooked();
        bit done;
        done = 1'b0;
        for (int n = 0; n < 4 * FRAME_CYCLES && !done; n++) begin
            @(negedge clock);
            done = !hooked;
        end
        if (!done)
            stop_on_error("timeout waiting for the hooked item to be collected");
    endtask

    initial begin
        logic [9:0] exp_deg;
        logic [9:0] held_deg;
        int         exp_len;
        int         exp_idx;
        int         got_len;
        bit         got_hook;
        int         fx;
        int         fy;

        resetn     = 1'b0;
        enable     = 1'b0;
        draw_busy  = 1'b0;
        fire_key   = 1'b0;
        draw_index = '0;
        load_en    = 1'b0;
        load_index = '0;
        load_data  = '0;
        rng_state  = 32'd44814;
        ref_score  = 0;

        //           x    y    type          angle hit   hold  score
        rows[0] = '{20,  200, ITEM_STONE,   30,   1'b0, 1'b0, 0};    // miss, off the screen edge
        rows[1] = '{152, 100, ITEM_GOLD,    90,   1'b1, 1'b0, 2};
        rows[2] = '{200, 120, ITEM_DIAMOND, 60,   1'b1, 1'b0, 7};
        rows[3] = '{104, 120, ITEM_STONE,   120,  1'b1, 1'b1, 8};

        // fillers sit right of X_HI where no tip can reach
        for (int i = 0; i < ITEM_COUNT; i++) begin
            if (i < ROWS) begin
                items[i] = make_word(rows[i].x, rows[i].y, rows[i].kind, 1'b1, 1'b0);
            end else begin
                rng_state = xorshift(rng_state);
                fx        = int'(X_HI) + int'(rng_state[15:0] % 16'd190);
                fy        = int'(rng_state[31:16] % 16'd230);
                items[i]  = make_word(fx, fy, item_type_e'(2'(i % 3)), 1'b1, 1'b0);
            end
        end

        repeat (3) @(posedge clock);
        resetn <= 1'b1;

        for (int i = 0; i < ITEM_COUNT; i++) begin
            @(posedge clock);
            load_en    <= 1'b1;
            load_index <= ITEM_AW'(i);
            load_data  <= items[i];
        end
        @(posedge clock);
        load_en <= 1'b0;

        @(negedge clock);
        check_degree(ANGLE_MAX);
        check_len("rope_len after reset", ROPE_MIN, rope_len);
        check_score(10'd0);
        check_hooked(1'b0, hooked);

        // one full swing, down to 20 and back to 160
        @(posedge clock);
        enable <= 1'b1;
        for (int s = 0; s < 28; s++) begin
            exp_deg = (s < 14) ? 10'(150 - 10 * s) : 10'(30 + 10 * (s - 14));
            wait_degree_step();
            check_degree(exp_deg);
        end

        // renderer busy freezes the frame steps
        @(posedge clock);
        draw_busy <= 1'b1;
        @(negedge clock);
        held_deg = degree;
        repeat (4 * FRAME_CYCLES) begin
            @(negedge clock);
            check_degree(held_deg);
        end
        @(posedge clock);
        draw_busy <= 1'b0;

        for (int r = 0; r < ROWS; r++) begin
            exp_len = predict_drop(rows[r].angle, exp_idx);
            if ((exp_idx >= 0) != rows[r].hit)
                stop_on_error($sformatf("row %0d hit flag disagrees with the tip model", r));
            wait_angle(10'(rows[r].angle));
            @(posedge clock);
            fire_key <= 1'b1;
            if (!rows[r].hold) begin
                repeat (4) @(posedge clock);
                fire_key <= 1'b0;
            end
            if (r == 0)
                hold_busy_in_drop();    // rope frozen mid drop
            run_drop(10'(rows[r].angle), got_len, got_hook);
            check_hooked(rows[r].hit, got_hook);
            check_len("max rope_len", 10'(exp_len), 10'(got_len));
            if (rows[r].hit) begin
                wait_unhooked();
                items[exp_idx][ITEM_VIS_BIT]  = 1'b0;
                items[exp_idx][ITEM_HOOK_BIT] = 1'b1;
                ref_score += item_value(rows[r].kind);
                check_item_word(exp_idx, rows[r].x, rows[r].y, rows[r].kind, 1'b0, 1'b1);
            end
            if (ref_score != rows[r].score)
                stop_on_error($sformatf("row %0d score in the table disagrees with item values", r));
            check_score(10'(rows[r].score));
            if (rows[r].hold) begin
                // key still high, no new edge so the claw keeps swinging
                for (int k = 0; k < 3; k++)
                    wait_degree_step();
                @(posedge clock);
                fire_key <= 1'b0;
            end
        end

        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

// File: rtl/claw_top.sv
// claw top: swing controller, trig table, fire key, item memory and score
`default_nettype none

module claw_top (
    input  wire                          clock,
    input  wire                          resetn,
    input  wire                          enable,
    input  wire                          draw_busy,
    input  wire                          fire_key,
    input  wire  [claw_pkg::ITEM_AW-1:0] draw_index,
    input  wire                          load_en,
    input  wire  [claw_pkg::ITEM_AW-1:0] load_index,
    input  wire  [31:0]                  load_data,
    output logic [9:0]                   degree,
    output logic [9:0]                   end_x,
    output logic [9:0]                   end_y,
    output logic [9:0]                   rope_len,
    output logic [31:0]                  draw_data,
    output logic [9:0]                   score,
    output logic                         hooked
);
    import claw_pkg::*;

    logic               fire_pending;
    logic               fire_take;
    logic [8:0]         cos_mag;
    logic [8:0]         sin_mag;
    logic               cos_neg;
    logic [ITEM_AW-1:0] rd_index;
    logic [31:0]        rd_data;
    logic               wr_en;
    logic [ITEM_AW-1:0] wr_index;
    logic [31:0]        wr_data;
    logic               add_en;
    item_type_e         add_type;

    angle_trig u_trig (
        .degree  (degree),
        .cos_mag (cos_mag),
        .sin_mag (sin_mag),
        .cos_neg (cos_neg)
    );

    key_pulse u_fire (
        .clock   (clock),
        .resetn  (resetn),
        .key     (fire_key),
        .take    (fire_take),
        .pending (fire_pending)
    );

    score_counter u_score (
        .clock    (clock),
        .resetn   (resetn),
        .add_en   (add_en),
        .add_type (add_type),
        .score    (score)
    );

    item_ram u_items (
        .clock      (clock),
        .load_en    (load_en),
        .load_index (load_index),
        .load_data  (load_data),
        .wr_en      (wr_en),
        .wr_index   (wr_index),
        .wr_data    (wr_data),
        .rd_index   (rd_index),
        .draw_index (draw_index),
        .rd_data    (rd_data),
        .draw_data  (draw_data)
    );

    claw_controller u_ctrl (
        .clock        (clock),
        .resetn       (resetn),
        .enable       (enable),
        .draw_busy    (draw_busy),
        .fire_pending (fire_pending),
        .cos_mag      (cos_mag),
        .sin_mag      (sin_mag),
        .cos_neg      (cos_neg),
        .rd_data      (rd_data),
        .fire_take    (fire_take),
        .degree       (degree),
        .end_x        (end_x),
        .end_y        (end_y),
        .rope_len     (rope_len),
        .rd_index     (rd_index),
        .wr_en        (wr_en),
        .wr_index     (wr_index),
        .wr_data      (wr_data),
        .add_en       (add_en),
        .add_type     (add_type),
        .hooked       (hooked)
    );

endmodule

`default_nettype wire

// File: rtl/claw_controller.sv
// claw controller: swing, drop, item hit scan and reel-in state machine
`default_nettype none

module claw_controller (
    input  wire                          clock,
    input  wire                          resetn,
    input  wire                          enable,
    input  wire                          draw_busy,
    input  wire                          fire_pending,
    input  wire  [8:0]                   cos_mag,
    input  wire  [8:0]                   sin_mag,
    input  wire                          cos_neg,
    input  wire  [31:0]                  rd_data,
    output logic                         fire_take,
    output logic [9:0]                   degree,
    output logic [9:0]                   end_x,
    output logic [9:0]                   end_y,
    output logic [9:0]                   rope_len,
    output logic [claw_pkg::ITEM_AW-1:0] rd_index,
    output logic                         wr_en,
    output logic [claw_pkg::ITEM_AW-1:0] wr_index,
    output logic [31:0]                  wr_data,
    output logic                         add_en,
    output claw_pkg::item_type_e         add_type,
    output logic                         hooked
);
    import claw_pkg::*;

    claw_state_e        state;
    logic [7:0]         frame_cnt;
    logic               tick;
    logic               dir_down;    // swinging toward ANGLE_MIN
    logic [ITEM_AW-1:0] scan_idx;
    logic [ITEM_AW-1:0] hook_idx;
    logic [31:0]        item_word;   // entry under test, then the hooked one

    logic [18:0] dx_prod;
    logic [18:0] dy_prod;
    logic [9:0]  dx;
    logic [9:0]  dy;
    logic        x_oob;
    logic        y_oob;
    logic        tip_out;
    logic [9:0]  item_x;
    logic [9:0]  item_y;
    logic        hit;

    // frame tick, counter frozen while the renderer is busy
    assign tick = (frame_cnt == 8'(FRAME_CYCLES - 1)) && !draw_busy;

    always_ff @(posedge clock) begin
        if (!resetn)
            frame_cnt <= 8'd0;
        else if (tick)
            frame_cnt <= 8'd0;
        else if (!draw_busy)
            frame_cnt <= frame_cnt + 8'd1;
    end

    // tip position
    assign dx_prod = rope_len * cos_mag;
    assign dy_prod = rope_len * sin_mag;
    assign dx      = dx_prod[17:8];
    assign dy      = dy_prod[17:8];
    assign end_x   = cos_neg ? ORIGIN_X - dx : ORIGIN_X + dx;
    assign end_y   = ORIGIN_Y + dy;

    // left side checked on dx so the tip never wraps below zero
    assign x_oob   = cos_neg ? (dx >= ORIGIN_X - X_LO) : (end_x >= X_HI);
    assign y_oob   = end_y >= Y_HI;
    assign tip_out = x_oob || y_oob || (rope_len >= ROPE_MAX);

    assign rd_index = scan_idx;
    assign wr_index = hook_idx;

    // hit box, exclusive on both ends
    assign item_x = {1'b0, item_word[ITEM_X_HI:ITEM_X_LO]};
    assign item_y = {2'b0, item_word[ITEM_Y_HI:ITEM_Y_LO]};
    assign hit    = item_word[ITEM_VIS_BIT] && !item_word[ITEM_HOOK_BIT]
                    && (item_x < end_x) && (end_x < item_x + ITEM_BOX)
                    && (item_y < end_y) && (end_y < item_y + ITEM_BOX);

    always_ff @(posedge clock) begin
        if (!resetn) begin
            state     <= ST_IDLE;
            degree    <= ANGLE_MAX;
            dir_down  <= 1'b1;
            rope_len  <= ROPE_MIN;
            scan_idx  <= '0;
            hook_idx  <= '0;
            hooked    <= 1'b0;
            fire_take <= 1'b0;
            wr_en     <= 1'b0;
            add_en    <= 1'b0;
        end else begin
            fire_take <= 1'b0;
            wr_en     <= 1'b0;
            add_en    <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (enable)
                        state <= ST_SWING;
                end
                ST_SWING: begin
                    if (!enable) begin
                        state <= ST_IDLE;
                    end else if (tick && fire_pending) begin
                        fire_take <= 1'b1;    // no angle step on this tick
                        state     <= ST_DROP;
                    end else if (tick) begin
                        if (dir_down && degree == ANGLE_MIN) begin
                            dir_down <= 1'b0;
                            degree   <= degree + ANGLE_STEP;
                        end else if (!dir_down && degree == ANGLE_MAX) begin
                            dir_down <= 1'b1;
                            degree   <= degree - ANGLE_STEP;
                        end else begin
                            degree <= dir_down ? degree - ANGLE_STEP : degree + ANGLE_STEP;
                        end
                    end
                end
                ST_DROP: begin
                    if (tick) begin
                        if (tip_out) begin
                            state <= ST_REEL;    // miss
                        end else begin
                            rope_len <= (rope_len > ROPE_MAX - DROP_STEP) ?
                                        ROPE_MAX : rope_len + DROP_STEP;
                            scan_idx <= '0;
                            state    <= ST_SCAN_ADDR;
                        end
                    end
                end
                ST_SCAN_ADDR: state <= ST_SCAN_DATA;    // ram read in flight
                ST_SCAN_DATA: begin
                    item_word <= rd_data;
                    state     <= ST_SCAN_TEST;
                end
                ST_SCAN_TEST: begin
                    if (hit) begin
                        hook_idx                 <= scan_idx;
                        hooked                   <= 1'b1;
                        item_word[ITEM_HOOK_BIT] <= 1'b1;
                        wr_data                  <= item_word;
                        wr_data[ITEM_HOOK_BIT]   <= 1'b1;
                        wr_en                    <= 1'b1;
                        state                    <= ST_HOOK;
                    end else if (scan_idx == ITEM_AW'(ITEM_COUNT - 1)) begin
                        state <= ST_DROP;
                    end else begin
                        scan_idx <= scan_idx + 1'b1;
                        state    <= ST_SCAN_ADDR;
                    end
                end
                ST_HOOK: state <= ST_REEL;    // hooked flag written back here
                ST_REEL: begin
                    if (tick) begin
                        if (rope_len > ROPE_MIN) begin
                            rope_len <= rope_len - REEL_STEP;
                        end else if (hooked) begin
                            wr_data               <= item_word;
                            wr_data[ITEM_VIS_BIT] <= 1'b0;
                            wr_en                 <= 1'b1;
                            add_en                <= 1'b1;
                            add_type <= item_type_e'(item_word[ITEM_TYPE_HI:ITEM_TYPE_LO]);
                            state                 <= ST_COLLECT;
                        end else begin
                            state <= ST_SWING;
                        end
                    end
                end
                ST_COLLECT: begin
                    hooked <= 1'b0;
                    state  <= ST_SWING;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    a_degree_range: assert property (@(posedge clock) disable iff (!resetn)
        degree >= ANGLE_MIN && degree <= ANGLE_MAX);
    a_rope_range: assert property (@(posedge clock) disable iff (!resetn)
        rope_len >= ROPE_MIN && rope_len <= ROPE_MAX);
    a_no_write_swing: assert property (@(posedge clock) disable iff (!resetn)
        state == ST_SWING |-> !wr_en);

endmodule

`default_nettype wire

// File: rtl/item_ram.sv
// item ram: 16 x 32 item memory, one write port and two registered read ports
`default_nettype none

module item_ram (
    input  wire                          clock,
    input  wire                          load_en,
    input  wire  [claw_pkg::ITEM_AW-1:0] load_index,
    input  wire  [31:0]                  load_data,
    input  wire                          wr_en,
    input  wire  [claw_pkg::ITEM_AW-1:0] wr_index,
    input  wire  [31:0]                  wr_data,
    input  wire  [claw_pkg::ITEM_AW-1:0] rd_index,
    input  wire  [claw_pkg::ITEM_AW-1:0] draw_index,
    output logic [31:0]                  rd_data,
    output logic [31:0]                  draw_data
);
    import claw_pkg::*;

    logic [31:0] mem [ITEM_COUNT];

    // single write port, load side first
    always_ff @(posedge clock) begin
        if (load_en)
            mem[load_index] <= load_data;
        else if (wr_en)
            mem[wr_index] <= wr_data;
    end

    // controller port
    always_ff @(posedge clock) begin
        rd_data <= mem[rd_index];
    end

    // renderer port
    always_ff @(posedge clock) begin
        draw_data <= mem[draw_index];
    end

endmodule

`default_nettype wire

// File: rtl/score_counter.sv
// score counter: adds item values on a strobe, saturating at 999
`default_nettype none

module score_counter (
    input  wire                  clock,
    input  wire                  resetn,
    input  wire                  add_en,
    input  wire claw_pkg::item_type_e add_type,
    output logic [9:0]           score
);
    import claw_pkg::*;

    logic [3:0]  add_val;
    logic [10:0] sum;

    always_comb begin
        case (add_type)
            ITEM_GOLD:    add_val = 4'd2;
            ITEM_DIAMOND: add_val = 4'd5;
            default:      add_val = 4'd1;    // stone
        endcase
    end

    assign sum = {1'b0, score} + {7'b0, add_val};

    always_ff @(posedge clock) begin
        if (!resetn)
            score <= 10'd0;
        else if (add_en)
            score <= (sum > {1'b0, SCORE_MAX}) ? SCORE_MAX : sum[9:0];
    end

    a_score_max: assert property (@(posedge clock) disable iff (!resetn) score <= SCORE_MAX);

endmodule

`default_nettype wire

// File: rtl/key_pulse.sv
// key pulse: fire key synchronizer with rising edge request latch
`default_nettype none

module key_pulse (
    input  wire  clock,
    input  wire  resetn,
    input  wire  key,
    input  wire  take,
    output logic pending
);

    logic sync0;
    logic sync1;
    logic key_q;    // last synced level
    logic rise;

    assign rise = sync1 & ~key_q;

    always_ff @(posedge clock) begin
        if (!resetn) begin
            sync0   <= 1'b0;
            sync1   <= 1'b0;
            key_q   <= 1'b0;
            pending <= 1'b0;
        end else begin
            sync0 <= key;
            sync1 <= sync0;
            key_q <= sync1;
            if (take)
                pending <= 1'b0;    // take wins over a new edge
            else if (rise)
                pending <= 1'b1;
        end
    end

    a_no_rise_on_take: assert property (@(posedge clock) disable iff (!resetn)
        $rose(pending) |-> !take);

endmodule

`default_nettype wire

// File: rtl/angle_trig.sv
// angle trig: cosine and sine magnitudes on the 10 degree grid, cosine sign
`default_nettype none

module angle_trig (
    input  wire  [9:0] degree,
    output logic [8:0] cos_mag,
    output logic [8:0] sin_mag,
    output logic       cos_neg
);

    // 256 * sin(a), a in 0..90
    function automatic logic [8:0] sin_lut(input logic [9:0] a);
        case (a)
            10'd0:   sin_lut = 9'd0;
            10'd10:  sin_lut = 9'd44;
            10'd20:  sin_lut = 9'd88;
            10'd30:  sin_lut = 9'd128;
            10'd40:  sin_lut = 9'd165;
            10'd50:  sin_lut = 9'd196;
            10'd60:  sin_lut = 9'd222;
            10'd70:  sin_lut = 9'd241;
            10'd80:  sin_lut = 9'd252;
            10'd90:  sin_lut = 9'd256;
            default: sin_lut = 9'd0;    // off grid
        endcase
    endfunction

    always_comb begin
        if (degree <= 10'd90) begin
            sin_mag = sin_lut(degree);
            cos_mag = sin_lut(10'd90 - degree);
            cos_neg = 1'b0;
        end else if (degree <= 10'd180) begin
            // second quadrant, mirror about 90
            sin_mag = sin_lut(10'd180 - degree);
            cos_mag = sin_lut(degree - 10'd90);
            cos_neg = 1'b1;
        end else begin
            sin_mag = 9'd0;
            cos_mag = 9'd0;
            cos_neg = 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: rtl/claw_pkg.sv
// claw package: geometry, timing, item word layout and shared enums
`default_nettype none

package claw_pkg;

    // rope pivot
    localparam logic [9:0] ORIGIN_X = 10'd160;
    localparam logic [9:0] ORIGIN_Y = 10'd45;

    localparam logic [9:0] ANGLE_MIN  = 10'd20;
    localparam logic [9:0] ANGLE_MAX  = 10'd160;
    localparam logic [9:0] ANGLE_STEP = 10'd10;

    localparam logic [9:0] ROPE_MIN  = 10'd20;
    localparam logic [9:0] ROPE_MAX  = 10'd275;
    localparam logic [9:0] DROP_STEP = 10'd2;    // px per frame going down
    localparam logic [9:0] REEL_STEP = 10'd1;

    // tip bounds
    localparam logic [9:0] X_LO = 10'd10;
    localparam logic [9:0] X_HI = 10'd310;
    localparam logic [9:0] Y_HI = 10'd230;

    localparam int FRAME_CYCLES = 6;    // short frame for sim
    localparam int ITEM_COUNT   = 16;
    localparam int ITEM_AW      = 4;
    localparam logic [9:0] ITEM_BOX  = 10'd16;
    localparam logic [9:0] SCORE_MAX = 10'd999;

    // item word fields
    localparam int ITEM_X_HI     = 31;
    localparam int ITEM_X_LO     = 23;
    localparam int ITEM_Y_HI     = 18;
    localparam int ITEM_Y_LO     = 11;
    localparam int ITEM_TYPE_HI  = 3;
    localparam int ITEM_TYPE_LO  = 2;
    localparam int ITEM_VIS_BIT  = 1;
    localparam int ITEM_HOOK_BIT = 0;

    typedef enum logic [1:0] {
        ITEM_STONE   = 2'd0,
        ITEM_GOLD    = 2'd1,
        ITEM_DIAMOND = 2'd2
    } item_type_e;

    typedef enum logic [3:0] {
        ST_IDLE, ST_SWING, ST_DROP, ST_SCAN_ADDR, ST_SCAN_DATA,
        ST_SCAN_TEST, ST_HOOK, ST_REEL, ST_COLLECT
    } claw_state_e;

endpackage

`default_nettype wire
